/* design/ex_pkg.sv */
//------------------------------
// execute cluster types, 32-bit data only
// opcode codes are internal, not MIPS encodings
//------------------------------
package ex_pkg;

    parameter int XLEN  = 32;
    parameter int NBYTE = XLEN / 8;

    typedef enum logic [5:0] {
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        CLZ,
        CLO,
        BAL,
        TEQ,
        TNE,
        TLT,
        TLTU,
        TGE,
        TGEU,
        LB,
        LH,
        LW,
        SB,
        SH,
        SW,
        SWL,
        SWR,
        LL,
        SC,
        ERET
    } ex_op_e;

    // decoded operation
    typedef struct packed {
        ex_op_e          op;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] opr1;
        logic [XLEN-1:0] opr2;
        logic [XLEN-1:0] offset;
        logic            usermode;
        logic            llbit;
    } ex_req_t;

    typedef struct packed {
        logic ov;
        logic trap;
        logic adel;
        logic ades;
    } ex_exc_t;

    typedef struct packed {
        logic [XLEN-1:0]  result;
        logic             mem_en;
        logic [NBYTE-1:0] mem_wen;
        logic [XLEN-1:0]  mem_addr;
        logic [XLEN-1:0]  mem_wdata;
        logic             llb_wen;
        logic             llbit;
        ex_exc_t          exc;
    } ex_resp_t;

endpackage

/* design/ex_dispatch.sv */
//------------------------------
// round-robin issue in strict lane order
// a full target lane stalls the input
//------------------------------
`timescale 1ns/10ps

module ex_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    output logic [NUM_LANES-1:0] lane_valid_o,
    input  logic [NUM_LANES-1:0] lane_ready_i
);

    localparam int PTR_W = $clog2(NUM_LANES);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(NUM_LANES - 1);

    logic [PTR_W-1:0] issue_ptr;
    logic             accept;

    assign in_ready_o = lane_ready_i[issue_ptr];
    assign accept     = in_valid_i && in_ready_o;

    // only the targeted lane sees the valid
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_valid_o[i] = in_valid_i && (issue_ptr == PTR_W'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            issue_ptr <= '0;
        end else if (accept) begin
            if (issue_ptr == LAST) begin
                issue_ptr <= '0;
            end else begin
                issue_ptr <= issue_ptr + 1'b1;
            end
        end
    end

    a_ptr_range: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        int'(issue_ptr) < NUM_LANES
    );

endmodule

/* design/ex_lane.sv */
//------------------------------
// one execute lane, response registered
// no mul/div, no load data path
//------------------------------
`timescale 1ns/10ps

module ex_lane import ex_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  ex_req_t  req_i,
    output logic     resp_valid_o,
    input  logic     resp_ready_i,
    output ex_resp_t resp_o
);

    logic [XLEN-1:0]       sum;
    logic [XLEN-1:0]       diff;
    logic [XLEN-1:0]       addr;
    logic [XLEN-1:0]       clz_src;
    logic [$clog2(XLEN):0] clz_cnt;
    logic                  clz_found;
    logic                  lt_s;
    logic                  lt_u;
    logic                  eq;
    logic [1:0]            boff;
    logic                  exc_user;
    logic                  accept;
    logic                  full;
    ex_resp_t              resp_d;
    ex_resp_t              resp_q;

    assign sum      = req_i.opr1 + req_i.opr2;
    assign diff     = req_i.opr1 - req_i.opr2;
    assign lt_s     = $signed(req_i.opr1) < $signed(req_i.opr2);
    assign lt_u     = req_i.opr1 < req_i.opr2;
    assign eq       = req_i.opr1 == req_i.opr2;
    assign addr     = req_i.opr1 + req_i.offset;
    assign boff     = addr[1:0];
    // kernel segment from user mode
    assign exc_user = req_i.usermode && addr[XLEN-1];

    // CLO counts zeros of the inverted operand
    always_comb begin
        clz_src   = (req_i.op == CLO) ? ~req_i.opr1 : req_i.opr1;
        clz_cnt   = ($clog2(XLEN) + 1)'(XLEN);
        clz_found = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (!clz_found && clz_src[i]) begin
                clz_cnt   = ($clog2(XLEN) + 1)'(XLEN - 1 - i);
                clz_found = 1'b1;
            end
        end
    end

    always_comb begin
        resp_d       = '0;
        resp_d.llbit = req_i.llbit;

        case (req_i.op)
            ADD, ADDU: resp_d.result = sum;
            SUB, SUBU: resp_d.result = diff;
            AND:       resp_d.result = req_i.opr1 & req_i.opr2;
            OR:        resp_d.result = req_i.opr1 | req_i.opr2;
            XOR:       resp_d.result = req_i.opr1 ^ req_i.opr2;
            NOR:       resp_d.result = ~(req_i.opr1 | req_i.opr2);
            SLL:       resp_d.result = req_i.opr2 << req_i.opr1[4:0];
            SRL:       resp_d.result = req_i.opr2 >> req_i.opr1[4:0];
            SRA:       resp_d.result = $signed(req_i.opr2) >>> req_i.opr1[4:0];
            SLT:       resp_d.result = XLEN'(lt_s);
            SLTU:      resp_d.result = XLEN'(lt_u);
            CLZ, CLO:  resp_d.result = XLEN'(clz_cnt);
            BAL:       resp_d.result = req_i.pc + XLEN'(8);
            SC:        resp_d.result = XLEN'(req_i.llbit);
            default:   resp_d.result = '0;
        endcase

        // signed overflow only when operand signs allow it
        case (req_i.op)
            ADD: resp_d.exc.ov = (req_i.opr1[XLEN-1] == req_i.opr2[XLEN-1]) &&
                                 (sum[XLEN-1] != req_i.opr1[XLEN-1]);
            SUB: resp_d.exc.ov = (req_i.opr1[XLEN-1] != req_i.opr2[XLEN-1]) &&
                                 (diff[XLEN-1] != req_i.opr1[XLEN-1]);
            default: resp_d.exc.ov = 1'b0;
        endcase

        case (req_i.op)
            TEQ:     resp_d.exc.trap = eq;
            TNE:     resp_d.exc.trap = !eq;
            TLT:     resp_d.exc.trap = lt_s;
            TLTU:    resp_d.exc.trap = lt_u;
            TGE:     resp_d.exc.trap = !lt_s;
            TGEU:    resp_d.exc.trap = !lt_u;
            default: resp_d.exc.trap = 1'b0;
        endcase

        case (req_i.op)
            LB, LH, LW: begin
                resp_d.mem_en   = 1'b1;
                resp_d.mem_addr = addr;
                resp_d.exc.adel = exc_user ||
                                  (req_i.op == LH && boff[0]) ||
                                  (req_i.op == LW && boff != 2'b00);
            end
            LL: begin
                resp_d.mem_en   = 1'b1;
                resp_d.mem_addr = addr;
                resp_d.exc.adel = exc_user || (boff != 2'b00);
                resp_d.llb_wen  = 1'b1;
                resp_d.llbit    = 1'b1;
            end
            SB: begin
                resp_d.mem_en    = 1'b1;
                resp_d.mem_addr  = addr;
                resp_d.mem_wdata = {4{req_i.opr2[7:0]}};
                resp_d.mem_wen   = 4'b0001 << boff;
                resp_d.exc.ades  = exc_user;
            end
            SH: begin
                resp_d.mem_en    = 1'b1;
                resp_d.mem_addr  = addr;
                resp_d.mem_wdata = {2{req_i.opr2[15:0]}};
                resp_d.mem_wen   = boff[0] ? 4'b0000 : (boff[1] ? 4'b1100 : 4'b0011);
                resp_d.exc.ades  = exc_user || boff[0];
            end
            SW: begin
                resp_d.mem_en    = 1'b1;
                resp_d.mem_addr  = addr;
                resp_d.mem_wdata = req_i.opr2;
                resp_d.mem_wen   = 4'b1111;
                resp_d.exc.ades  = exc_user || (boff != 2'b00);
            end
            // partial stores, 3 - boff is ~boff
            SWL: begin
                resp_d.mem_en    = 1'b1;
                resp_d.mem_addr  = {addr[XLEN-1:2], 2'b00};
                resp_d.mem_wdata = req_i.opr2 >> {~boff, 3'b000};
                resp_d.mem_wen   = 4'b1111 >> ~boff;
                resp_d.exc.ades  = exc_user;
            end
            SWR: begin
                resp_d.mem_en    = 1'b1;
                resp_d.mem_addr  = {addr[XLEN-1:2], 2'b00};
                resp_d.mem_wdata = req_i.opr2 << {boff, 3'b000};
                resp_d.mem_wen   = 4'b1111 << boff;
                resp_d.exc.ades  = exc_user;
            end
            SC: begin
                resp_d.exc.ades = exc_user || (boff != 2'b00);
                if (req_i.llbit) begin
                    resp_d.mem_en    = 1'b1;
                    resp_d.mem_addr  = addr;
                    resp_d.mem_wdata = req_i.opr2;
                    resp_d.mem_wen   = 4'b1111;
                end
            end
            ERET: begin
                resp_d.llb_wen = 1'b1;
                resp_d.llbit   = 1'b0;
            end
            default: ;
        endcase
    end

    // one-entry output register
    assign req_ready_o  = !full || resp_ready_i;
    assign accept       = req_valid_i && req_ready_o;
    assign resp_valid_o = full;
    assign resp_o       = resp_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (resp_ready_i) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_q <= resp_d;
        end
    end

    a_resp_hold: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_o))
    );

endmodule

/* design/ex_retire.sv */
//------------------------------
// drains lanes in issue order
// output is combinational from the lane registers
//------------------------------
`timescale 1ns/10ps

module ex_retire import ex_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic [NUM_LANES-1:0] lane_valid_i,
    input  ex_resp_t             lane_resp_i [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_ready_o,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output ex_resp_t             out_resp_o
);

    localparam int PTR_W = $clog2(NUM_LANES);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(NUM_LANES - 1);

    logic [PTR_W-1:0] drain_ptr;
    logic             handshake;

    assign out_valid_o = lane_valid_i[drain_ptr];
    assign out_resp_o  = lane_resp_i[drain_ptr];
    assign handshake   = out_valid_o && out_ready_i;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_ready_o[i] = out_ready_i && (drain_ptr == PTR_W'(i));
        end
    end

    // same wrap order as the dispatcher
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            drain_ptr <= '0;
        end else if (handshake) begin
            if (drain_ptr == LAST) begin
                drain_ptr <= '0;
            end else begin
                drain_ptr <= drain_ptr + 1'b1;
            end
        end
    end

    a_valid_hold: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (out_valid_o && !out_ready_i) |=> out_valid_o
    );

endmodule

/* design/ex_cluster.sv */
//------------------------------
// NUM_LANES identical lanes, 2 to 8
// one cycle latency without back-pressure
//------------------------------
`timescale 1ns/10ps

module ex_cluster import ex_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  ex_req_t  in_req_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output ex_resp_t out_resp_o
);

    logic [NUM_LANES-1:0] req_valid;
    logic [NUM_LANES-1:0] req_ready;
    logic [NUM_LANES-1:0] resp_valid;
    logic [NUM_LANES-1:0] resp_ready;
    ex_resp_t             resp [NUM_LANES];

    ex_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) ex_dispatch_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .lane_valid_o (req_valid),
        .lane_ready_i (req_ready)
    );

    // request bus is shared by all lanes
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        ex_lane ex_lane_i (
            .clk          (clk),
            .arst_n_i     (arst_n_i),
            .req_valid_i  (req_valid[g]),
            .req_ready_o  (req_ready[g]),
            .req_i        (in_req_i),
            .resp_valid_o (resp_valid[g]),
            .resp_ready_i (resp_ready[g]),
            .resp_o       (resp[g])
        );
    end

    ex_retire #(
        .NUM_LANES (NUM_LANES)
    ) ex_retire_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .lane_valid_i (resp_valid),
        .lane_resp_i  (resp),
        .lane_ready_o (resp_ready),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_resp_o   (out_resp_o)
    );

endmodule

/* verif/ex_model.svh */
//------------------------------
// expected lane response per request
// needs ex_pkg types in scope
//------------------------------
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

function automatic logic [31:0] lead_zeros(logic [31:0] x);
    for (int i = 31; i >= 0; i--) begin
        if (x[i]) begin
            return 32'(31 - i);
        end
    end
    return 32'd32;
endfunction

function automatic ex_resp_t expected_resp(ex_req_t r);
    ex_resp_t    e;
    logic [32:0] wide;
    logic [31:0] addr;
    logic        user;
    logic        mis;
    int          bi;
    e = '0;
    e.llbit = r.llbit;
    addr = r.opr1 + r.offset;
    bi = int'(addr[1:0]);
    user = r.usermode && addr[31];
    mis = (r.op inside {LH, SH}) ? addr[0] :
          (r.op inside {LW, SW, LL, SC}) ? (addr[1:0] != 2'b00) : 1'b0;
    case (r.op)
        ADD, ADDU: e.result = r.opr1 + r.opr2;
        SUB, SUBU: e.result = r.opr1 - r.opr2;
        AND:       e.result = r.opr1 & r.opr2;
        OR:        e.result = r.opr1 | r.opr2;
        XOR:       e.result = r.opr1 ^ r.opr2;
        NOR:       e.result = ~(r.opr1 | r.opr2);
        SLL:       e.result = r.opr2 << r.opr1[4:0];
        SRL:       e.result = r.opr2 >> r.opr1[4:0];
        SRA:       e.result = $signed(r.opr2) >>> r.opr1[4:0];
        SLT:       e.result = 32'($signed(r.opr1) < $signed(r.opr2));
        SLTU:      e.result = 32'(r.opr1 < r.opr2);
        CLZ:       e.result = lead_zeros(r.opr1);
        CLO:       e.result = lead_zeros(~r.opr1);
        BAL:       e.result = r.pc + 32'd8;
        SC:        e.result = 32'(r.llbit);
        default:   e.result = '0;
    endcase
    // sign-extended 33-bit sum, overflow when the top two bits differ
    if (r.op == ADD || r.op == SUB) begin
        wide = (r.op == ADD) ? {r.opr1[31], r.opr1} + {r.opr2[31], r.opr2}
                             : {r.opr1[31], r.opr1} - {r.opr2[31], r.opr2};
        e.exc.ov = wide[32] != wide[31];
    end
    case (r.op)
        TEQ:     e.exc.trap = r.opr1 == r.opr2;
        TNE:     e.exc.trap = r.opr1 != r.opr2;
        TLT:     e.exc.trap = $signed(r.opr1) < $signed(r.opr2);
        TLTU:    e.exc.trap = r.opr1 < r.opr2;
        TGE:     e.exc.trap = $signed(r.opr1) >= $signed(r.opr2);
        TGEU:    e.exc.trap = r.opr1 >= r.opr2;
        default: e.exc.trap = 1'b0;
    endcase
    if (r.op inside {LB, LH, LW, LL}) begin
        e.mem_en = 1'b1;
        e.mem_addr = addr;
        e.exc.adel = user || mis;
    end
    if (r.op inside {SB, SH, SW, SWL, SWR, SC}) begin
        e.exc.ades = user || mis;
    end
    case (r.op)
        LL: begin
            e.llb_wen = 1'b1;
            e.llbit = 1'b1;
        end
        ERET: begin
            e.llb_wen = 1'b1;
            e.llbit = 1'b0;
        end
        SB: begin
            e.mem_en = 1'b1;
            e.mem_addr = addr;
            e.mem_wdata = {4{r.opr2[7:0]}};
            e.mem_wen = 4'b0001 << addr[1:0];
        end
        SH: begin
            e.mem_en = 1'b1;
            e.mem_addr = addr;
            e.mem_wdata = {2{r.opr2[15:0]}};
            e.mem_wen = mis ? 4'b0000 : (4'b0011 << addr[1:0]);
        end
        SW: begin
            e.mem_en = 1'b1;
            e.mem_addr = addr;
            e.mem_wdata = r.opr2;
            e.mem_wen = 4'b1111;
        end
        // SWL fills bytes bi..0 from the top of the register, SWR bytes 3..bi from the bottom
        SWL, SWR: begin
            e.mem_en = 1'b1;
            e.mem_addr = {addr[31:2], 2'b00};
            for (int k = 0; k < 4; k++) begin
                if (r.op == SWL && k <= bi) begin
                    e.mem_wen[k] = 1'b1;
                    e.mem_wdata[8*k +: 8] = r.opr2[8*(k + 3 - bi) +: 8];
                end else if (r.op == SWR && k >= bi) begin
                    e.mem_wen[k] = 1'b1;
                    e.mem_wdata[8*k +: 8] = r.opr2[8*(k - bi) +: 8];
                end
            end
        end
        SC: begin
            if (r.llbit) begin
                e.mem_en = 1'b1;
                e.mem_addr = addr;
                e.mem_wdata = r.opr2;
                e.mem_wen = 4'b1111;
            end
        end
        default: ;
    endcase
    return e;
endfunction

`endif

/* verif/tb_ex_cluster.sv */
//------------------------------
// random ops with random back-pressure
// stops at the first mismatch
//------------------------------
`timescale 1ns/10ps

module tb_ex_cluster
    import ex_pkg::*;
();

    localparam int          NUM_OPS      = 400;
    localparam int          MAX_CYCLES   = NUM_OPS * 8;
    localparam int          DRAIN_CYCLES = 8;
    localparam logic [15:0] SEED         = 16'd51262;

    logic     clk;
    logic     arst_n_i;
    logic     in_valid_i;
    logic     in_ready_o;
    ex_req_t  in_req_i;
    logic     out_valid_o;
    logic     out_ready_i;
    ex_resp_t out_resp_o;

    logic [15:0] lfsr_q;
    ex_resp_t    exp_q [$];
    int          issued;
    int          accepted;
    int          retired;
    int          cycles;

    `include "ex_model.svh"

    ex_cluster ex_cluster_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_req_i    (in_req_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_resp_o  (out_resp_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic take_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], take_bit()};
        end
        return v;
    endfunction

    // one in four operands is a corner value
    function automatic logic [31:0] pick_operand();
        logic [31:0] v;
        if (rand_bits(2) != 0) begin
            v = rand_bits(32);
        end else begin
            case (rand_bits(2))
                0:       v = 32'h0000_0000;
                1:       v = 32'hffff_ffff;
                2:       v = 32'h7fff_ffff;
                default: v = 32'h8000_0000;
            endcase
        end
        return v;
    endfunction

    function automatic ex_req_t new_request();
        ex_req_t     r;
        logic [31:0] off;
        r.op = ex_op_e'(6'(rand_bits(6) % 32'd33));
        r.pc = rand_bits(30) << 2;
        r.opr1 = pick_operand();
        r.opr2 = pick_operand();
        off = rand_bits(16);
        r.offset = {{16{off[15]}}, off[15:0]};
        r.usermode = rand_bits(1) != 0;
        r.llbit = rand_bits(1) != 0;
        return r;
    endfunction

    task automatic check_equal(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // scoreboard sampled on the handshake edge
    always @(posedge clk) begin
        ex_resp_t want;
        if (arst_n_i) begin
            if (in_valid_i && in_ready_o) begin
                exp_q.push_back(expected_resp(in_req_i));
                accepted++;
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("t=%0t response left the cluster with no request pending", $time);
                    $display("Testbench failed");
                    $fatal(1, "extra response");
                end
                want = exp_q.pop_front();
                check_equal("result", out_resp_o.result, want.result);
                check_equal("mem_en", 32'(out_resp_o.mem_en), 32'(want.mem_en));
                check_equal("mem_wen", 32'(out_resp_o.mem_wen), 32'(want.mem_wen));
                check_equal("mem_addr", out_resp_o.mem_addr, want.mem_addr);
                check_equal("mem_wdata", out_resp_o.mem_wdata, want.mem_wdata);
                check_equal("llb_wen", 32'(out_resp_o.llb_wen), 32'(want.llb_wen));
                check_equal("llbit", 32'(out_resp_o.llbit), 32'(want.llbit));
                check_equal("exc", 32'(out_resp_o.exc), 32'(want.exc));
                retired++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen",
                     cycles, retired, NUM_OPS);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic acc;
        lfsr_q = SEED;
        issued = 0;
        accepted = 0;
        retired = 0;
        cycles = 0;
        arst_n_i = 1'b0;
        in_valid_i = 1'b0;
        in_req_i = '0;
        out_ready_i = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        check_equal("out_valid_o", 32'(out_valid_o), 32'd0);
        check_equal("in_ready_o", 32'(in_ready_o), 32'd1);

        while (accepted < NUM_OPS) begin
            @(posedge clk);
            acc = in_valid_i && in_ready_o;
            #1;
            // a raised valid holds its request until accepted
            if (!in_valid_i || acc) begin
                if (issued < NUM_OPS && rand_bits(1) != 0) begin
                    in_valid_i = 1'b1;
                    in_req_i = new_request();
                    issued++;
                end else begin
                    in_valid_i = 1'b0;
                end
            end
            out_ready_i = rand_bits(1) != 0;
        end

        // with ready held high each full lane drains in one cycle
        out_ready_i = 1'b1;
        repeat (DRAIN_CYCLES) @(posedge clk);
        #1;
        if (exp_q.size() != 0) begin
            $display("%0d accepted requests never produced a response", exp_q.size());
            $display("Testbench failed");
            $fatal(1, "lost responses");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* filelist.f */
+incdir+verif
design/ex_pkg.sv
design/ex_dispatch.sv
design/ex_lane.sv
design/ex_retire.sv
design/ex_cluster.sv
verif/tb_ex_cluster.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_cluster
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the simulator output decides pass or fail
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
